//--- design/qla_pkg.sv
package qla_pkg;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    typedef enum logic [3:0] {
        ADDR_MAIN     = 4'h0,   // board and axis registers
        ADDR_HUB      = 4'h1,
        ADDR_PROM     = 4'h2,
        ADDR_PROM_QLA = 4'h3,
        ADDR_ETH      = 4'h4,
        ADDR_FW       = 4'h5,
        ADDR_DS       = 4'h6,
        ADDR_DATA_BUF = 4'h7,
        ADDR_WAVEFORM = 4'h8
    } addr_space_e;

    typedef struct packed {
        logic [3:0] space;      // compared against addr_space_e
        logic [3:0] rsvd;       // not decoded
        logic [3:0] chan;       // 0 = board, 1..4 = axes
        logic [3:0] offset;     // register within channel
    } reg_addr_t;

    localparam int         NUM_AXES     = 4;
    localparam int         AXIS_W       = $clog2(NUM_AXES);
    localparam logic [3:0] OFF_STATUS   = 4'd0;   // chan 0 only
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;   // chan 1..4

    typedef logic [15:0] cur_t;     // unsigned current, cmd and feedback

    // ----------------------------------------
    // bus structs
    // ----------------------------------------
    typedef struct packed {
        logic        wen;           // quadlet write
        logic        blk_wen;       // block write quadlet
        logic        blk_wstart;    // first quadlet of block
        reg_addr_t   waddr;
        logic [31:0] wdata;
    } reg_wr_bus_t;

    typedef struct packed {
        logic        wen;
        logic [2:0]  waddr;         // quadlet 0..4
        logic [31:0] wdata;
    } rt_wr_t;

    // status word layout (read side)
    localparam int ST_AMP_LSB    = 0;
    localparam int ST_SAFETY_LSB = 8;
    localparam int ST_PWR_BIT    = 19;
    localparam int ST_BOARD_LSB  = 28;

    // status write word, amp values share ST_AMP_LSB
    localparam int WR_AMP_MASK_LSB = 8;
    localparam int WR_PWR_VAL_BIT  = 18;
    localparam int WR_PWR_MASK_BIT = 19;

    // over-current check
    localparam cur_t SAFETY_MARGIN = 16'd64;
    localparam int   SAFETY_COUNT  = 8;     // consecutive over-limit cycles
    localparam int   SAFETY_CNT_W  = $clog2(SAFETY_COUNT);

    // real-time block write
    typedef enum logic {
        RT_IDLE  = 1'b0,
        RT_BURST = 1'b1
    } rt_state_e;

    localparam int RT_QUADS = 5;            // 4 axis cmds + ctrl word
    localparam int RT_CNT_W = $clog2(RT_QUADS);

endpackage

//--- design/register_bus.sv
`timescale 1ns/1ns

module register_bus import qla_pkg::*; (
    // write masters
    input  reg_wr_bus_t fw_wr,
    input  reg_wr_bus_t eth_wr,
    input  logic        eth_write_en,   // eth owns write bus
    input  reg_wr_bus_t bw_wr,
    input  logic        bw_write_en,    // rt burst owns write bus
    // read masters
    input  reg_addr_t   fw_raddr,
    input  reg_addr_t   eth_raddr,
    input  logic        eth_read_en,
    // real-time quadlets
    input  rt_wr_t      fw_rt,
    input  rt_wr_t      eth_rt,
    // read sources
    input  logic [31:0] status_word,
    input  cur_t        cur_cmd [NUM_AXES],
    // selected buses
    output reg_wr_bus_t sel_wr,
    output rt_wr_t      sel_rt,
    output logic [31:0] reg_rdata
);

    reg_addr_t raddr;   // active read address

    // ----------------------------------------
    // write bus owner
    // ----------------------------------------
    always_comb begin
        if (bw_write_en) begin
            sel_wr = bw_wr;         // burst beats everyone
        end else if (eth_write_en) begin
            sel_wr = eth_wr;
        end else begin
            sel_wr = fw_wr;         // default owner
        end
    end

    // eth quadlet wins a tie
    assign sel_rt = eth_rt.wen ? eth_rt : fw_rt;

    // ----------------------------------------
    // read address and data routing
    // ----------------------------------------
    assign raddr = eth_read_en ? eth_raddr : fw_raddr;

    always_comb begin
        reg_rdata = 32'd0;  // unmapped reads return 0
        if (raddr.space == ADDR_MAIN) begin
            // board channel
            if (raddr.chan == 4'd0 && raddr.offset == OFF_STATUS) begin
                reg_rdata = status_word;
            end
            // axis channels, cmd zero-extended
            for (int k = 0; k < NUM_AXES; k++) begin
                if (raddr.chan == 4'(k + 1) && raddr.offset == OFF_DAC_CTRL) begin
                    reg_rdata = {16'd0, cur_cmd[k]};
                end
            end
        end
    end

endmodule

//--- design/rt_block_writer.sv
`timescale 1ns/1ns

module rt_block_writer import qla_pkg::*; (
    input  logic        sysclk,
    input  logic        rst_n,
    input  rt_wr_t      sel_rt,         // winning rt quadlet
    output reg_wr_bus_t bw_wr,
    output logic        bw_write_en     // high for the whole burst
);

    rt_state_e             state;
    logic [RT_CNT_W-1:0]   burst_cnt;   // beat within burst
    cur_t                  cmd_buf [NUM_AXES];
    logic [31:0]           ctrl_word;   // quadlet 4, goes to status reg
    logic                  rt_accept;
    logic                  rt_last;

    // quadlets only taken while idle, dropped during burst
    assign rt_accept = sel_rt.wen && (state == RT_IDLE);
    assign rt_last   = sel_rt.waddr == 3'(RT_QUADS - 1);

    // ----------------------------------------
    // quadlet buffer
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rt_accept) begin
            if (sel_rt.waddr < 3'(NUM_AXES)) begin
                cmd_buf[sel_rt.waddr[AXIS_W-1:0]] <= sel_rt.wdata[15:0];  // low half only
            end else if (rt_last) begin
                ctrl_word <= sel_rt.wdata;
            end
        end
    end

    // ----------------------------------------
    // burst FSM
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RT_IDLE;
            burst_cnt <= '0;
        end else begin
            case (state)
                RT_IDLE: begin
                    if (rt_accept && rt_last) begin    // quadlet 4 kicks off replay
                        state     <= RT_BURST;
                        burst_cnt <= '0;
                    end
                end
                RT_BURST: begin
                    if (burst_cnt == RT_CNT_W'(RT_QUADS - 1)) begin
                        state <= RT_IDLE;
                    end else begin
                        burst_cnt <= burst_cnt + 1'b1;
                    end
                end
                default: state <= RT_IDLE;
            endcase
        end
    end

    assign bw_write_en = (state == RT_BURST);

    // beats 0..3 -> axis dac regs as block write, beat 4 -> status reg
    always_comb begin
        bw_wr = '0;
        if (state == RT_BURST) begin
            bw_wr.waddr.space = ADDR_MAIN;
            if (burst_cnt < RT_CNT_W'(NUM_AXES)) begin
                bw_wr.blk_wen      = 1'b1;
                bw_wr.blk_wstart   = (burst_cnt == '0);
                bw_wr.waddr.chan   = 4'(burst_cnt) + 4'd1;  // axis k is chan k+1
                bw_wr.waddr.offset = OFF_DAC_CTRL;
                bw_wr.wdata        = {16'd0, cmd_buf[burst_cnt[AXIS_W-1:0]]};
            end else begin
                bw_wr.wen          = 1'b1;
                bw_wr.waddr.chan   = 4'd0;
                bw_wr.waddr.offset = OFF_STATUS;
                bw_wr.wdata        = ctrl_word;
            end
        end
    end

endmodule

//--- design/dac_cmd_regs.sv
`timescale 1ns/1ns

module dac_cmd_regs import qla_pkg::*; (
    input  logic        sysclk,
    input  logic        rst_n,
    input  reg_wr_bus_t sel_wr,                 // arbitrated write bus
    output cur_t        cur_cmd [NUM_AXES]      // current command per axis
);

    logic                wr_strobe;    // quadlet or block beat
    logic                main_space;
    logic [NUM_AXES-1:0] dac_hit;      // one-hot axis select

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign wr_strobe  = sel_wr.wen || sel_wr.blk_wen;
    assign main_space = (sel_wr.waddr.space == ADDR_MAIN);

    always_comb begin
        for (int k = 0; k < NUM_AXES; k++) begin
            dac_hit[k] = wr_strobe && main_space
                      && (sel_wr.waddr.chan == 4'(k + 1))    // chan 0 is board
                      && (sel_wr.waddr.offset == OFF_DAC_CTRL);
        end
    end

    // ----------------------------------------
    // command registers
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_AXES; k++) begin
                cur_cmd[k] <= '0;   // zero current out of reset
            end
        end else begin
            for (int k = 0; k < NUM_AXES; k++) begin
                if (dac_hit[k]) begin
                    cur_cmd[k] <= sel_wr.wdata[15:0];   // upper half ignored
                end
            end
        end
    end

endmodule

//--- design/safety_monitor.sv
`timescale 1ns/1ns

module safety_monitor import qla_pkg::*; (
    input  logic sysclk,
    input  logic rst_n,
    input  cur_t cur_fb,            // measured current
    input  cur_t cur_cmd,           // commanded current
    input  logic clear_disable,     // one-cycle clear from status write
    output logic amp_disable        // sticky trip
);

    logic [17:0]             limit;      // 2*cmd + margin, no overflow
    logic                    over_limit;
    logic [SAFETY_CNT_W-1:0] over_cnt;   // consecutive over-limit edges

    // widened so 2*cmd + margin never wraps
    assign limit      = {1'b0, cur_cmd, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over_limit = {2'b00, cur_fb} > limit;

    // ----------------------------------------
    // trip counter
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin       // clear wins over a trip
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (over_limit) begin
            if (over_cnt == SAFETY_CNT_W'(SAFETY_COUNT - 1)) begin
                amp_disable <= 1'b1;            // hold count, stay tripped
            end else begin
                over_cnt <= over_cnt + 1'b1;
            end
        end else begin
            over_cnt <= '0;     // glitch filtered, start over
        end
    end

endmodule

//--- design/board_status_regs.sv
`timescale 1ns/1ns

module board_status_regs import qla_pkg::*; (
    input  logic                sysclk,
    input  logic                rst_n,
    input  reg_wr_bus_t         sel_wr,
    input  logic [3:0]          board_id,
    input  logic [NUM_AXES-1:0] safety_disable,  // from safety monitors
    output logic [31:0]         status_word,
    output logic [NUM_AXES-1:0] clear_disable,   // one-cycle per-axis clear
    output logic [NUM_AXES-1:0] amp_enable,      // gated enables to amps
    output logic                pwr_enable
);

    logic                status_hit;
    logic [NUM_AXES-1:0] amp_val;
    logic [NUM_AXES-1:0] amp_mask;
    logic                pwr_val;
    logic                pwr_mask;
    logic [NUM_AXES-1:0] amp_en_reg;     // requested amp enables
    logic                pwr_en_reg;

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign status_hit = sel_wr.wen                        // quadlet writes only
                     && (sel_wr.waddr.space == ADDR_MAIN)
                     && (sel_wr.waddr.chan == 4'd0)
                     && (sel_wr.waddr.offset == OFF_STATUS);

    assign amp_val  = sel_wr.wdata[ST_AMP_LSB +: NUM_AXES];
    assign amp_mask = sel_wr.wdata[WR_AMP_MASK_LSB +: NUM_AXES];
    assign pwr_val  = sel_wr.wdata[WR_PWR_VAL_BIT];
    assign pwr_mask = sel_wr.wdata[WR_PWR_MASK_BIT];

    // ----------------------------------------
    // enable registers and clear pulses
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_en_reg    <= '0;
            pwr_en_reg    <= 1'b0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;    // pulse by default
            if (status_hit) begin
                amp_en_reg <= (amp_en_reg & ~amp_mask) | (amp_val & amp_mask);
                if (pwr_mask) begin
                    pwr_en_reg <= pwr_val;
                end
                // enabling an amp re-arms its monitor
                // power on re-arms all of them
                if (pwr_mask && pwr_val) begin
                    clear_disable <= '1;
                end else begin
                    clear_disable <= amp_val & amp_mask;
                end
            end
        end
    end

    // amp only runs with power on and no safety trip
    assign amp_enable = amp_en_reg & ~safety_disable & {NUM_AXES{pwr_en_reg}};
    assign pwr_enable = pwr_en_reg;

    // status readback
    always_comb begin
        status_word                              = 32'd0;
        status_word[ST_AMP_LSB +: NUM_AXES]      = amp_en_reg;
        status_word[ST_SAFETY_LSB +: NUM_AXES]   = safety_disable;
        status_word[ST_PWR_BIT]                  = pwr_en_reg;
        status_word[ST_BOARD_LSB +: 4]           = board_id;
    end

endmodule

//--- design/qla_core_top.sv
`timescale 1ns/1ns

module qla_core_top import qla_pkg::*; (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic [3:0]          board_id,       // rotary switch
    // write masters
    input  reg_wr_bus_t         fw_wr,
    input  reg_wr_bus_t         eth_wr,
    input  logic                eth_write_en,
    // read masters
    input  reg_addr_t           fw_raddr,
    input  reg_addr_t           eth_raddr,
    input  logic                eth_read_en,
    // real-time quadlets
    input  rt_wr_t              fw_rt,
    input  rt_wr_t              eth_rt,
    // measured currents
    input  cur_t                cur_fb [NUM_AXES],
    output logic [31:0]         reg_rdata,
    output cur_t                cur_cmd [NUM_AXES],
    output logic [NUM_AXES-1:0] amp_enable,
    output logic                pwr_enable
);

    // ----------------------------------------
    // internal buses
    // ----------------------------------------
    reg_wr_bus_t         sel_wr;        // arbitrated write bus
    rt_wr_t              sel_rt;        // winning rt quadlet
    reg_wr_bus_t         bw_wr;         // burst master
    logic                bw_write_en;
    logic [31:0]         status_word;
    logic [NUM_AXES-1:0] safety_disable;
    logic [NUM_AXES-1:0] clear_disable;

    register_bus u_register_bus (
        .fw_wr       (fw_wr),
        .eth_wr      (eth_wr),
        .eth_write_en(eth_write_en),
        .bw_wr       (bw_wr),
        .bw_write_en (bw_write_en),
        .fw_raddr    (fw_raddr),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .fw_rt       (fw_rt),
        .eth_rt      (eth_rt),
        .status_word (status_word),
        .cur_cmd     (cur_cmd),
        .sel_wr      (sel_wr),
        .sel_rt      (sel_rt),
        .reg_rdata   (reg_rdata)
    );

    rt_block_writer u_rt_block_writer (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .sel_rt     (sel_rt),
        .bw_wr      (bw_wr),
        .bw_write_en(bw_write_en)
    );

    dac_cmd_regs u_dac_cmd_regs (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .sel_wr (sel_wr),
        .cur_cmd(cur_cmd)
    );

    board_status_regs u_board_status_regs (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .sel_wr        (sel_wr),
        .board_id      (board_id),
        .safety_disable(safety_disable),
        .status_word   (status_word),
        .clear_disable (clear_disable),
        .amp_enable    (amp_enable),
        .pwr_enable    (pwr_enable)
    );

    // one over-current monitor per axis
    for (genvar k = 0; k < NUM_AXES; k++) begin : gen_safety
        safety_monitor u_safety_monitor (
            .sysclk       (sysclk),
            .rst_n        (rst_n),
            .cur_fb       (cur_fb[k]),
            .cur_cmd      (cur_cmd[k]),
            .clear_disable(clear_disable[k]),
            .amp_disable  (safety_disable[k])
        );
    end

endmodule

//--- verification/tb_qla_core.sv
`timescale 1ns/1ns

module tb_qla_core import qla_pkg::*; ();

    localparam int N_RANDOM    = 20;                // fw access iterations
    localparam int CYC_TOTAL   = 12 + N_RANDOM * 6 + 14 + 16 + 26;
    localparam int WATCHDOG_NS = CYC_TOTAL * 20 + 400;

    logic                sysclk = 1'b0;
    logic                rst_n;
    logic [3:0]          board_id;
    reg_wr_bus_t         fw_wr;
    reg_wr_bus_t         eth_wr;
    logic                eth_write_en;
    reg_addr_t           fw_raddr;
    reg_addr_t           eth_raddr;
    logic                eth_read_en;
    rt_wr_t              fw_rt;
    rt_wr_t              eth_rt;
    cur_t                cur_fb [NUM_AXES];
    logic [31:0]         reg_rdata;
    cur_t                cur_cmd [NUM_AXES];
    logic [NUM_AXES-1:0] amp_enable;
    logic                pwr_enable;

    // ----------------------------------------
    // reference model state
    // ----------------------------------------
    cur_t                mdl_cmd [NUM_AXES];
    logic [NUM_AXES-1:0] mdl_amp;
    logic                mdl_pwr;
    logic [NUM_AXES-1:0] mdl_dis;        // sticky safety trips
    logic [NUM_AXES-1:0] mdl_clr;        // clear due at next edge
    int                  mdl_over [NUM_AXES];
    cur_t                mdl_rt_cmd [NUM_AXES];
    logic [31:0]         mdl_rt_ctrl;
    logic                mdl_burst;
    int                  mdl_beat;

    integer seed = 32'h9f85;
    int     errors = 0;
    int     checks = 0;
    int     test_errors = 0;
    int     tests_run = 0;

    qla_core_top u_dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .board_id    (board_id),
        .fw_wr       (fw_wr),
        .eth_wr      (eth_wr),
        .eth_write_en(eth_write_en),
        .fw_raddr    (fw_raddr),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .fw_rt       (fw_rt),
        .eth_rt      (eth_rt),
        .cur_fb      (cur_fb),
        .reg_rdata   (reg_rdata),
        .cur_cmd     (cur_cmd),
        .amp_enable  (amp_enable),
        .pwr_enable  (pwr_enable)
    );

    always #10 sysclk = ~sysclk;    // 20 ns period

    function automatic reg_addr_t dac_addr(input int axis);
        reg_addr_t a;
        a        = '0;              // main space
        a.chan   = 4'(axis + 1);
        a.offset = OFF_DAC_CTRL;
        return a;
    endfunction

    function automatic reg_addr_t status_addr();
        reg_addr_t a;
        a        = '0;
        a.offset = OFF_STATUS;      // board channel 0
        return a;
    endfunction

    function automatic logic [31:0] status_expected();
        logic [31:0] s;
        s                              = 32'd0;
        s[ST_AMP_LSB +: NUM_AXES]      = mdl_amp;
        s[ST_SAFETY_LSB +: NUM_AXES]   = mdl_dis;
        s[ST_PWR_BIT]                  = mdl_pwr;
        s[ST_BOARD_LSB +: 4]           = board_id;
        return s;
    endfunction

    function automatic logic [31:0] read_expected(input reg_addr_t a);
        int ch;
        ch = int'(a.chan);
        if (a.space != 4'h0) return 32'd0;
        if (ch == 0 && a.offset == OFF_STATUS) return status_expected();
        if (ch >= 1 && ch <= NUM_AXES && a.offset == OFF_DAC_CTRL) return {16'd0, mdl_cmd[ch - 1]};
        return 32'd0;               // unmapped
    endfunction

    // masked amp and power update
    // enabling re-arms the monitors
    function automatic void apply_status(input logic [31:0] d);
        logic [NUM_AXES-1:0] val;
        logic [NUM_AXES-1:0] mask;
        val     = d[3:0];
        mask    = d[11:8];
        mdl_amp = (mdl_amp & ~mask) | (val & mask);
        if (d[19]) mdl_pwr = d[18];
        mdl_clr = (d[19] && d[18]) ? '1 : (val & mask);
    endfunction

    function automatic void apply_write(input reg_wr_bus_t w);
        int ch;
        ch = int'(w.waddr.chan);
        if (w.waddr.space != 4'h0) return;
        if ((w.wen || w.blk_wen) && w.waddr.offset == OFF_DAC_CTRL && ch >= 1 && ch <= NUM_AXES)
            mdl_cmd[ch - 1] = w.wdata[15:0];
        if (w.wen && ch == 0 && w.waddr.offset == OFF_STATUS) apply_status(w.wdata);
    endfunction

    // one clock edge of the model
    // inputs read as driven on the falling edge
    function automatic void model_edge();
        rt_wr_t q;
        int     lim;
        int     idx;
        for (int k = 0; k < NUM_AXES; k++) begin
            lim = 2 * int'(mdl_cmd[k]) + int'(SAFETY_MARGIN);   // cmd before this edge
            if (mdl_clr[k]) begin
                mdl_over[k] = 0;
                mdl_dis[k]  = 1'b0;
            end else if (int'(cur_fb[k]) > lim) begin
                mdl_over[k]++;
                if (mdl_over[k] >= SAFETY_COUNT) mdl_dis[k] = 1'b1;
            end else begin
                mdl_over[k] = 0;
            end
        end
        mdl_clr = '0;
        if (mdl_burst) begin        // burst owns the bus and drops host and rt writes
            if (mdl_beat < NUM_AXES) mdl_cmd[mdl_beat] = mdl_rt_cmd[mdl_beat];
            else apply_status(mdl_rt_ctrl);
            mdl_beat++;
            if (mdl_beat == RT_QUADS) mdl_burst = 1'b0;
        end else begin
            apply_write(eth_write_en ? eth_wr : fw_wr);
            q   = eth_rt.wen ? eth_rt : fw_rt;
            idx = int'(q.waddr);
            if (q.wen && idx < NUM_AXES) mdl_rt_cmd[idx] = q.wdata[15:0];
            if (q.wen && idx == RT_QUADS - 1) begin
                mdl_rt_ctrl = q.wdata;
                mdl_burst   = 1'b1;
                mdl_beat    = 0;
            end
        end
    endfunction

    // ----------------------------------------
    // stimulus and check helpers
    // ----------------------------------------
    task automatic step();
        @(posedge sysclk);
        model_edge();
        @(negedge sysclk);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic host_write(input bit use_eth, input reg_addr_t a, input logic [31:0] d);
        reg_wr_bus_t w;
        w       = '0;
        w.wen   = 1'b1;
        w.waddr = a;
        w.wdata = d;
        if (use_eth) begin
            eth_wr       = w;
            eth_write_en = 1'b1;
        end else begin
            fw_wr = w;
        end
        step();
        fw_wr        = '0;
        eth_wr       = '0;
        eth_write_en = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t a, input string name);
        fw_raddr = a;
        step();
        compare(name, read_expected(a), reg_rdata);
    endtask

    task automatic check_outputs(input string name);
        for (int k = 0; k < NUM_AXES; k++)
            compare($sformatf("%s cmd%0d", name, k), {16'd0, mdl_cmd[k]}, {16'd0, cur_cmd[k]});
        compare({name, " amp_enable"}, 32'(mdl_amp & ~mdl_dis & {NUM_AXES{mdl_pwr}}),
                32'(amp_enable));
        compare({name, " pwr_enable"}, 32'(mdl_pwr), 32'(pwr_enable));
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int          axis;
        int          kind;
        rt_wr_t      quad;
        reg_wr_bus_t w;
        cur_t        cmd_val;
        rst_n        = 1'b0;
        board_id     = 4'($random(seed));
        fw_wr        = '0;
        eth_wr       = '0;
        eth_write_en = 1'b0;
        fw_raddr     = '0;
        eth_raddr    = '0;
        eth_read_en  = 1'b0;
        fw_rt        = '0;
        eth_rt       = '0;
        for (int k = 0; k < NUM_AXES; k++) begin
            cur_fb[k]     = '0;
            mdl_cmd[k]    = '0;
            mdl_over[k]   = 0;
            mdl_rt_cmd[k] = '0;
        end
        {mdl_amp, mdl_pwr, mdl_dis, mdl_clr, mdl_rt_ctrl, mdl_burst} = '0;
        mdl_beat = 0;
        repeat (5) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        // reset values with only the board id in the status word
        fw_raddr = status_addr();
        step();
        compare("reset status", {board_id, 28'd0}, reg_rdata);
        for (int k = 0; k < NUM_AXES; k++) begin
            fw_raddr = dac_addr(k);
            step();
            compare("reset dac", 32'd0, reg_rdata);
        end
        compare("reset enables", 32'd0, {27'd0, pwr_enable, amp_enable});
        end_test("reset");

        // random fw writes and read-back
        for (int i = 0; i < N_RANDOM; i++) begin
            axis = $random(seed) & 3;
            kind = $random(seed) & 3;
            if (kind < 2) host_write(1'b0, dac_addr(axis), $random(seed));
            else if (kind == 2) host_write(1'b0, status_addr(), $random(seed));
            read_check(dac_addr(axis), "fw dac readback");
            read_check(status_addr(), "fw status readback");
            read_check(reg_addr_t'(16'($random(seed))), "fw random read");
            read_check({8'h00, 4'(5 + ($random(seed) & 7)), 4'($random(seed))}, "fw high chan");
            check_outputs("fw");
        end
        end_test("fw_access");

        // same-cycle fw and eth writes where eth owns the bus
        for (int i = 0; i < 4; i++) begin
            w       = '0;
            w.wen   = 1'b1;
            w.waddr = dac_addr(i);
            w.wdata = $random(seed);
            fw_wr   = w;
            w.wdata = ~w.wdata;     // conflicting value
            eth_wr  = w;
            eth_write_en = 1'b1;
            step();
            {fw_wr, eth_wr, eth_write_en} = '0;
            read_check(dac_addr(i), "eth write wins");
        end
        w.wdata      = ~w.wdata;    // differs from the stored eth value
        fw_wr        = w;           // eth owns an idle bus so the fw write is lost
        eth_write_en = 1'b1;
        step();
        {fw_wr, eth_write_en} = '0;
        check_outputs("fw blocked");
        fw_raddr    = dac_addr(1);
        eth_raddr   = status_addr();
        eth_read_en = 1'b1;
        step();
        compare("eth read wins", read_expected(eth_raddr), reg_rdata);
        eth_read_en = 1'b0;
        step();
        compare("fw read", read_expected(fw_raddr), reg_rdata);
        end_test("priority");

        // five rt quadlets where eth wins a tie
        for (int q = 0; q < RT_QUADS; q++) begin
            kind       = $random(seed) & 3;
            quad       = '0;
            quad.wen   = 1'b1;
            quad.waddr = 3'(q);
            quad.wdata = $random(seed);
            if (kind == 0) begin
                fw_rt = quad;
            end else if (kind == 1) begin
                eth_rt = quad;
            end else begin
                eth_rt     = quad;
                quad.wdata = ~quad.wdata;
                fw_rt      = quad;
            end
            step();
            {fw_rt, eth_rt} = '0;
        end
        for (int i = 0; i < 6; i++) begin
            if (i < NUM_AXES) begin             // late quadlets must be dropped
                quad.waddr = 3'(NUM_AXES - 1 - i);
                quad.wdata = $random(seed);
                fw_rt      = quad;
            end
            if (i == 1) fw_wr = '{1'b1, 1'b0, 1'b0, dac_addr(2), $random(seed)};  // lost
            step();
            {fw_rt, fw_wr} = '0;
        end
        check_outputs("rt burst");
        read_check(status_addr(), "rt status");
        end_test("rt_block");

        // over-current trip on one axis
        host_write(1'b1, status_addr(), 32'h000C0F0F);     // power and all amps on via eth
        axis    = $random(seed) & 3;
        cmd_val = cur_t'({4'd0, 12'($random(seed))});
        host_write(1'b0, dac_addr(axis), {16'd0, cmd_val});
        check_outputs("trip armed");
        cur_fb[axis] = cur_t'(2 * int'(cmd_val) + int'(SAFETY_MARGIN) + 1 + ($random(seed) & 255));
        repeat (SAFETY_COUNT + 2) step();
        read_check(status_addr(), "trip status");
        compare("trip safety bit", 32'd1, 32'(reg_rdata[ST_SAFETY_LSB + axis]));
        compare("trip amp_enable", 32'(4'hF & ~(4'b1 << axis)), 32'(amp_enable));
        cur_fb[axis] = '0;
        repeat (2) step();
        read_check(status_addr(), "trip sticky");
        host_write(1'b0, status_addr(), (32'd1 << axis) | (32'd1 << (WR_AMP_MASK_LSB + axis)));
        step();                     // clear lands one edge after the write
        read_check(status_addr(), "rearm status");
        compare("rearm amp_enable", 32'h0000000F, 32'(amp_enable));
        check_outputs("rearm");
        end_test("safety_trip");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // hang guard sized from the test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- compile.f
design/qla_pkg.sv
design/register_bus.sv
design/rt_block_writer.sv
design/dac_cmd_regs.sv
design/safety_monitor.sv
design/board_status_regs.sv
design/qla_core_top.sv
verification/tb_qla_core.sv

//--- Makefile
# Verilator flow for the register bus testbench

TOP = tb_qla_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

# pass or fail is taken from the printed result line
sim:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
